// ==== design/msg_pkg.sv ====
package msg_pkg;

	// buffer geometry
	localparam int DATA_WIDTH = 5;			// buffer address width
	localparam int BUF_DEPTH = 32;			// 2**DATA_WIDTH words
	localparam int OCC_W = DATA_WIDTH + 1;		// occupancy count must reach BUF_DEPTH

	// message table geometry
	localparam int NUM_MESSAGE = 10;
	localparam int SLOT_W = 4;			// holds 0 to NUM_MESSAGE

	localparam int WORD_W = 8;

	typedef logic [DATA_WIDTH-1:0] addr_t;
	typedef logic [SLOT_W-1:0] slot_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [OCC_W-1:0] occ_t;

	// framing FSM of the location controller
	typedef enum logic [0:0] {
		LOC_IDLE = 1'b0,		// no message open
		LOC_IN_MSG = 1'b1		// start recorded, waiting for eop
	} loc_state_e;

endpackage

// ==== design/msg_data_buf.sv ====
`timescale 1ns/10ps

module msg_data_buf import msg_pkg::*; (
	input  logic	clk,
	input  logic	rst,
	input  logic	clear_i,

	input  logic	wr_en_i,
	input  word_t	wr_data_i,

	input  logic	rd_data_en_i,
	input  addr_t	rd_addr_i,

	output logic	wr_accept_o,
	output addr_t	wr_ptr_o,
	output logic	full_o,
	output word_t	rd_data_o
);

	word_t	mem [BUF_DEPTH];
	addr_t	wr_ptr;
	occ_t	occ;
	logic	full_q;
	logic	wr_accept;
	logic	rd_hit;
	word_t	rd_data_q;

	// a word goes in only when there is room and no clear this cycle
	assign wr_accept = wr_en_i && !full_q && !clear_i;

	// read of the address being written this cycle sees the new word
	assign rd_hit = wr_accept && (rd_addr_i == wr_ptr);

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			wr_ptr <= '0;
		end else if (wr_accept) begin
			if (wr_ptr == addr_t'(BUF_DEPTH - 1))
				wr_ptr <= '0;		// wrap
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// words are never freed singly, so occupancy only climbs until clear
	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			occ <= '0;
			full_q <= 1'b0;
		end else if (wr_accept) begin
			occ <= occ + 1'b1;
			if (occ == occ_t'(BUF_DEPTH - 1))
				full_q <= 1'b1;		// this word fills the last location
		end
	end

	always_ff @(posedge clk) begin
		if (rd_data_en_i) begin
			if (rd_hit)
				rd_data_q <= wr_data_i;
			else
				rd_data_q <= mem[rd_addr_i];
		end
	end

	assign wr_accept_o = wr_accept;
	assign wr_ptr_o = wr_ptr;
	assign full_o = full_q;
	assign rd_data_o = rd_data_q;

	a_occ_bound: assert property (@(posedge clk) disable iff (rst)
		occ <= occ_t'(BUF_DEPTH))
		else $error("buffer occupancy above depth");

endmodule

// ==== design/message_loc.sv ====
`timescale 1ns/10ps

module message_loc import msg_pkg::*; (
	input  logic	clk,
	input  logic	rst,

	input  addr_t	start_i,
	input  addr_t	end_i,
	input  logic	store_start_i,
	input  logic	store_end_i,
	input  slot_t	addr_i,

	input  logic	re_i,
	input  slot_t	rd_slot_i,

	output addr_t	start_o,
	output addr_t	end_o,
	output logic	rd_valid_o
);

	addr_t	start_mem [NUM_MESSAGE];
	addr_t	end_mem [NUM_MESSAGE];
	addr_t	start_q;
	addr_t	end_q;
	logic	rd_valid_q;
	logic	rd_in_range;

	assign rd_in_range = (rd_slot_i < slot_t'(NUM_MESSAGE));

	always_ff @(posedge clk) begin
		if (store_start_i)
			start_mem[addr_i] <= start_i;
		if (store_end_i)
			end_mem[addr_i] <= end_i;
	end

	// a slot stored on the same edge as the read returns the new value
	always_ff @(posedge clk) begin
		if (re_i) begin
			if (store_start_i && addr_i == rd_slot_i)
				start_q <= start_i;
			else if (rd_in_range)
				start_q <= start_mem[rd_slot_i];
			else
				start_q <= '0;

			if (store_end_i && addr_i == rd_slot_i)
				end_q <= end_i;
			else if (rd_in_range)
				end_q <= end_mem[rd_slot_i];
			else
				end_q <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= re_i;		// one cycle per strobe
	end

	assign start_o = start_q;
	assign end_o = end_q;
	assign rd_valid_o = rd_valid_q;

	a_slot_range: assert property (@(posedge clk) disable iff (rst)
		(store_start_i || store_end_i) |-> (addr_i < slot_t'(NUM_MESSAGE)))
		else $error("slot store outside the table");

endmodule

// ==== design/message_loc_cntrl.sv ====
`timescale 1ns/10ps

module message_loc_cntrl import msg_pkg::*; (
	input  logic	clk,
	input  logic	rst,
	input  logic	clear_i,

	input  logic	wr_accept_i,
	input  logic	sop_i,
	input  logic	eop_i,
	input  addr_t	wr_ptr_i,

	input  logic	re_i,
	input  slot_t	rd_slot_i,

	output addr_t	start_o,
	output addr_t	end_o,
	output logic	rd_valid_o,
	output slot_t	msg_count_o
);

	loc_state_e	state;
	loc_state_e	next_state;
	slot_t		count;
	logic		slot_free;
	logic		store_start;
	logic		store_end;
	slot_t		slot_addr;
	addr_t		start_addr;
	addr_t		end_addr;

	// a new message may only open while a slot is left
	assign slot_free = (count < slot_t'(NUM_MESSAGE));

	always_comb begin
		next_state = state;
		store_start = 1'b0;
		store_end = 1'b0;
		case (state)
			LOC_IDLE: begin
				// stray eop without sop is dropped here
				if (wr_accept_i && sop_i && slot_free) begin
					store_start = 1'b1;
					if (eop_i)
						store_end = 1'b1;	// single word message
					else
						next_state = LOC_IN_MSG;
				end
			end
			LOC_IN_MSG: begin
				// repeated sop inside a message is ignored
				if (wr_accept_i && eop_i) begin
					store_end = 1'b1;
					next_state = LOC_IDLE;
				end
			end
			default: begin
				next_state = LOC_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || clear_i)
			state <= LOC_IDLE;
		else
			state <= next_state;
	end

	// slot count moves on the end word itself with no separate close state
	always_ff @(posedge clk) begin
		if (rst || clear_i)
			count <= '0;
		else if (store_end && slot_free)
			count <= count + 1'b1;
	end

	assign slot_addr = count;		// open message always sits in slot count
	assign start_addr = wr_ptr_i;
	assign end_addr = wr_ptr_i;
	assign msg_count_o = count;

	message_loc u_message_loc (
		.clk		(clk),
		.rst		(rst),
		.start_i	(start_addr),
		.end_i		(end_addr),
		.store_start_i	(store_start),
		.store_end_i	(store_end),
		.addr_i		(slot_addr),
		.re_i		(re_i),
		.rd_slot_i	(rd_slot_i),
		.start_o	(start_o),
		.end_o		(end_o),
		.rd_valid_o	(rd_valid_o)
	);

	a_no_store_when_full: assert property (@(posedge clk) disable iff (rst)
		(count == slot_t'(NUM_MESSAGE)) |-> !(store_start || store_end))
		else $error("slot store with table full");

	a_end_in_idle: assert property (@(posedge clk) disable iff (rst)
		(store_end && state == LOC_IDLE) |-> sop_i)
		else $error("message end recorded with no message open");

endmodule

// ==== design/msg_store_top.sv ====
`timescale 1ns/10ps

module msg_store_top import msg_pkg::*; (
	input  logic	clk,
	input  logic	rst,

	// write side
	input  logic	wr_en_i,
	input  word_t	wr_data_i,
	input  logic	sop_i,
	input  logic	eop_i,

	input  logic	clear_i,

	// slot read
	input  logic	re_i,
	input  slot_t	rd_slot_i,
	output addr_t	start_o,
	output addr_t	end_o,
	output logic	rd_valid_o,

	// data read
	input  logic	rd_data_en_i,
	input  addr_t	rd_addr_i,
	output word_t	rd_data_o,

	// status
	output logic	full_o,
	output slot_t	msg_count_o
);

	logic	wr_accept;
	addr_t	wr_ptr;		// address the current word takes

	msg_data_buf u_data_buf (
		.clk		(clk),
		.rst		(rst),
		.clear_i	(clear_i),
		.wr_en_i	(wr_en_i),
		.wr_data_i	(wr_data_i),
		.rd_data_en_i	(rd_data_en_i),
		.rd_addr_i	(rd_addr_i),
		.wr_accept_o	(wr_accept),
		.wr_ptr_o	(wr_ptr),
		.full_o		(full_o),
		.rd_data_o	(rd_data_o)
	);

	// framing flags only count on words the buffer took
	message_loc_cntrl u_loc_cntrl (
		.clk		(clk),
		.rst		(rst),
		.clear_i	(clear_i),
		.wr_accept_i	(wr_accept),
		.sop_i		(sop_i),
		.eop_i		(eop_i),
		.wr_ptr_i	(wr_ptr),
		.re_i		(re_i),
		.rd_slot_i	(rd_slot_i),
		.start_o	(start_o),
		.end_o		(end_o),
		.rd_valid_o	(rd_valid_o),
		.msg_count_o	(msg_count_o)
	);

endmodule

// ==== test/msg_store_model.svh ====
`ifndef MSG_STORE_MODEL_SVH
`define MSG_STORE_MODEL_SVH

// expected contents of buffer and slot table, with flags for entries ever written
word_t	m_mem [BUF_DEPTH];
bit	m_mem_ok [BUF_DEPTH];
addr_t	m_start [NUM_MESSAGE];
addr_t	m_end [NUM_MESSAGE];
bit	m_start_ok [NUM_MESSAGE];
bit	m_end_ok [NUM_MESSAGE];
addr_t	m_ptr;
int	m_occ;
bit	m_full;
bit	m_in_msg;		// a message is open
slot_t	m_count;

// expected read results after the last edge
bit	m_rd_valid;
addr_t	m_rd_start;
addr_t	m_rd_end;
bit	m_rd_start_ok;
bit	m_rd_end_ok;
word_t	m_rd_data;
bit	m_rd_data_ok;

function automatic void model_empty();
	m_ptr = '0;
	m_occ = 0;
	m_full = 1'b0;
	m_count = '0;
	m_in_msg = 1'b0;
	foreach (m_mem_ok[i])
		m_mem_ok[i] = 1'b0;
	for (int i = 0; i < NUM_MESSAGE; i++) begin
		m_start_ok[i] = 1'b0;
		m_end_ok[i] = 1'b0;
	end
endfunction

// one clock edge with the inputs sampled at that edge
task automatic model_step(input bit rst_v, input bit clear_v, input bit wr_v,
	input word_t data_v, input bit sop_v, input bit eop_v, input bit re_v,
	input slot_t slot_v, input bit rd_v, input addr_t addr_v);
	bit take;
	bit st;
	bit en;
	if (rst_v) begin
		model_empty();
		m_rd_valid = 1'b0;
		m_rd_data_ok = 1'b0;
	end else begin
		take = wr_v && !m_full && !clear_v;
		st = take && !m_in_msg && sop_v && (m_count < NUM_MESSAGE);
		en = take && (m_in_msg ? eop_v : (st && eop_v));
		if (take) begin
			m_mem[m_ptr] = data_v;
			m_mem_ok[m_ptr] = 1'b1;
		end
		if (st) begin
			m_start[m_count] = m_ptr;
			m_start_ok[m_count] = 1'b1;
		end
		if (en) begin
			m_end[m_count] = m_ptr;
			m_end_ok[m_count] = 1'b1;
		end
		// reads see entries written on the same edge
		m_rd_valid = re_v;
		if (re_v) begin
			m_rd_start = m_start[slot_v];
			m_rd_end = m_end[slot_v];
			m_rd_start_ok = m_start_ok[slot_v];
			m_rd_end_ok = m_end_ok[slot_v];
		end
		if (rd_v) begin
			m_rd_data = m_mem[addr_v];
			m_rd_data_ok = m_mem_ok[addr_v];
		end
		if (clear_v) begin
			model_empty();
		end else begin
			if (take) begin
				m_ptr = addr_t'((int'(m_ptr) + 1) % BUF_DEPTH);
				m_occ++;
				m_full = (m_occ == BUF_DEPTH);
			end
			if (en) begin
				m_count++;
				m_in_msg = 1'b0;
			end else if (st) begin
				m_in_msg = 1'b1;
			end
		end
	end
endtask

`endif

// ==== test/tb_msg_store.sv ====
`timescale 1ns/10ps

module tb_msg_store import msg_pkg::*; ();

	localparam int RESET_CYC = 10;
	localparam int ROUNDS = 8;
	localparam int ROUND_CYC = 1 + 5 * 7 + 8;		// clear, 5 messages, idle tail
	localparam int FILL_CYC = 1 + 40 + 20;
	localparam int SAT_CYC = 1 + 13 * 2 + 3 * 7 + 20;
	localparam int STRAY_CYC = 1 + 30 * 2 + 20;
	localparam int TAIL_CYC = 4;
	localparam int TIMEOUT_CYC = (RESET_CYC + ROUNDS * ROUND_CYC + FILL_CYC + SAT_CYC
		+ STRAY_CYC + TAIL_CYC) * 3 / 2;

	bit	clk;
	logic	rst;
	logic	wr_en_i;
	word_t	wr_data_i;
	logic	sop_i;
	logic	eop_i;
	logic	clear_i;
	logic	re_i;
	slot_t	rd_slot_i;
	addr_t	start_o;
	addr_t	end_o;
	logic	rd_valid_o;
	logic	rd_data_en_i;
	addr_t	rd_addr_i;
	word_t	rd_data_o;
	logic	full_o;
	slot_t	msg_count_o;

	integer	seed = 32'h670d;
	int	cycle_count = 0;

	msg_store_top u_dut (.*);

	`include "msg_store_model.svh"

	initial begin
		forever #20 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_slot(input string name, input slot_t got, input slot_t exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_flag(input string name, input bit got, input bit exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	// inputs only change by nba, so this sees what the DUT samples
	always @(posedge clk)
		model_step(rst, clear_i, wr_en_i, wr_data_i, sop_i, eop_i, re_i, rd_slot_i,
			rd_data_en_i, rd_addr_i);

	always @(negedge clk) begin
		check_flag("full_o", full_o, m_full);
		check_slot("msg_count_o", msg_count_o, m_count);
		check_flag("rd_valid_o", rd_valid_o, m_rd_valid);
		if (m_rd_valid && m_rd_start_ok)
			check_addr("start_o", start_o, m_rd_start);
		if (m_rd_valid && m_rd_end_ok)
			check_addr("end_o", end_o, m_rd_end);
		if (m_rd_data_ok)
			check_word("rd_data_o", rd_data_o, m_rd_data);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYC) begin
			$display("timeout: run went past %0d cycles", TIMEOUT_CYC);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	function automatic bit flip_coin();
		return ($random(seed) % 2) == 0;
	endfunction

	// read side is random on every cycle but idle during a clear
	task automatic drive_cycle(input bit wr, input bit sop, input bit eop, input bit clr);
		@(posedge clk);
		wr_en_i <= wr;
		wr_data_i <= word_t'($random(seed));
		sop_i <= sop;
		eop_i <= eop;
		clear_i <= clr;
		re_i <= !clr && (($random(seed) % 3) == 0);
		rd_slot_i <= slot_t'($unsigned($random(seed)) % NUM_MESSAGE);
		rd_data_en_i <= flip_coin();
		rd_addr_i <= addr_t'($random(seed));
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic clear_store();
		drive_cycle(flip_coin(), flip_coin(), flip_coin(), 1'b1);	// write with clear is dropped
	endtask

	task automatic send_message();
		int len;
		int gap;
		len = 1 + $unsigned($random(seed)) % 4;
		for (int i = 0; i < len; i++)
			drive_cycle(1'b1, i == 0, i == len - 1, 1'b0);
		gap = $unsigned($random(seed)) % 4;	// 0 gives back to back messages
		repeat (gap) idle_cycle();
	endtask

	initial begin
		rst = 1'b1;
		wr_en_i = 1'b0;
		wr_data_i = '0;
		sop_i = 1'b0;
		eop_i = 1'b0;
		clear_i = 1'b0;
		re_i = 1'b0;
		rd_slot_i = '0;
		rd_data_en_i = 1'b0;
		rd_addr_i = '0;
		repeat (RESET_CYC) @(posedge clk);
		rst <= 1'b0;

		repeat (ROUNDS) begin
			clear_store();
			repeat (5) send_message();
			repeat (8) idle_cycle();
		end

		// overfill so words past 32 are dropped
		clear_store();
		repeat (40) drive_cycle(1'b1, flip_coin(), flip_coin(), 1'b0);
		repeat (20) idle_cycle();
		@(negedge clk);
		check_flag("full_o", full_o, 1'b1);

		// more messages than slots
		clear_store();
		repeat (13) begin
			drive_cycle(1'b1, 1'b1, 1'b1, 1'b0);
			idle_cycle();
		end
		repeat (3) send_message();
		repeat (20) idle_cycle();
		@(negedge clk);
		check_slot("msg_count_o", msg_count_o, slot_t'(NUM_MESSAGE));

		// stray eop in idle and repeated sop inside messages
		clear_store();
		repeat (30) begin
			drive_cycle(1'b1, flip_coin(), flip_coin(), 1'b0);
			if (flip_coin())
				idle_cycle();
		end
		repeat (20) idle_cycle();

		repeat (TAIL_CYC) @(posedge clk);
		@(negedge clk);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+test
design/msg_pkg.sv
design/msg_data_buf.sv
design/message_loc.sv
design/message_loc_cntrl.sv
design/msg_store_top.sv
test/tb_msg_store.sv
